// ==== Makefile ====
TOP := decode_slice_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== dv/decode_slice_tb.sv ====
`timescale 1ns/1ps

`include "decode_defines.svh"

module decode_slice_tb;

  import instr_pkg::*;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 16;
  localparam int NUM_CYCLES     = 4000;
  localparam int DRAIN_LIMIT    = 200;
  localparam int SEED           = 72351;
  localparam int PLANNED_CYCLES = RESET_CYCLES + NUM_CYCLES + DRAIN_LIMIT;

  typedef struct packed {
    addr_t     pc;
    arch_reg_t src0;
    arch_reg_t src1;
    arch_reg_t dest;
    word_t     imm;
  } exp_item_t;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 flush;
  logic [`FETCH_WIDTH-1:0]              wr_valid;
  addr_t [`FETCH_WIDTH-1:0]             wr_pc;
  instr_t [`FETCH_WIDTH-1:0]            wr_instr;
  src_type_e [`FETCH_WIDTH-1:0]         wr_src0_type;
  src_type_e [`FETCH_WIDTH-1:0]         wr_src1_type;
  dest_type_e [`FETCH_WIDTH-1:0]        wr_dest_type;
  imm_type_e [`FETCH_WIDTH-1:0]         wr_imm_type;
  logic                                 wr_ready;
  logic                                 dec_ready;
  logic [`DECODE_WIDTH-1:0]             dec_valid;
  addr_t [`DECODE_WIDTH-1:0]            dec_pc;
  arch_reg_t [`DECODE_WIDTH-1:0]        dec_src0;
  arch_reg_t [`DECODE_WIDTH-1:0]        dec_src1;
  arch_reg_t [`DECODE_WIDTH-1:0]        dec_dest;
  word_t [`DECODE_WIDTH-1:0]            dec_imm;

  // accepted instructions not yet taken at the output, oldest first
  exp_item_t model_q [$];

  int value_errors;
  int protocol_errors;
  int timeout_errors;
  int items_checked;
  int flush_count;

  logic                     flush_seen;
  logic                     hold_pending;
  logic [`DECODE_WIDTH-1:0] held_valid;
  exp_item_t                held_item [`DECODE_WIDTH];

  decode_slice dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush),
    .wr_valid_i     (wr_valid),
    .wr_pc_i        (wr_pc),
    .wr_instr_i     (wr_instr),
    .wr_src0_type_i (wr_src0_type),
    .wr_src1_type_i (wr_src1_type),
    .wr_dest_type_i (wr_dest_type),
    .wr_imm_type_i  (wr_imm_type),
    .wr_ready_o     (wr_ready),
    .dec_ready_i    (dec_ready),
    .dec_valid_o    (dec_valid),
    .dec_pc_o       (dec_pc),
    .dec_src0_o     (dec_src0),
    .dec_src1_o     (dec_src1),
    .dec_dest_o     (dec_dest),
    .dec_imm_o      (dec_imm)
  );

  // ====================
  // reference decode

  function automatic arch_reg_t expect_src(input src_type_e code, input instr_t ins);
    case (code)
      SRC_R0:  return 5'd0;
      SRC_RD:  return ins[4:0];
      SRC_RJ:  return ins[9:5];
      default: return ins[14:10];
    endcase
  endfunction

  function automatic arch_reg_t expect_dest(input dest_type_e code, input instr_t ins);
    case (code)
      DEST_R0: return 5'd0;
      DEST_RD: return ins[4:0];
      DEST_JD: return ins[9:5] | ins[4:0];
      default: return 5'd1;
    endcase
  endfunction

  function automatic word_t expect_imm(input imm_type_e code, input instr_t ins, input addr_t pc);
    case (code)
      IMM_UI5:  return {27'd0, ins[14:10]};
      IMM_UI12: return {20'd0, ins[21:10]};
      IMM_SI12: return {{20{ins[21]}}, ins[21:10]};
      IMM_SI14: return {{18{ins[23]}}, ins[23:10]};
      IMM_SI16: return {{16{ins[25]}}, ins[25:10]};
      IMM_SI20: return {{12{ins[24]}}, ins[24:5]};
      IMM_SI26: return {{6{ins[9]}}, ins[9:0], ins[25:10]};
      IMM_PC:   return pc + {{12{ins[24]}}, ins[24:5]};
      default:  return 32'd0;
    endcase
  endfunction

  function automatic exp_item_t model_item(input int i);
    exp_item_t it;
    it.pc   = wr_pc[i];
    it.src0 = expect_src(wr_src0_type[i], wr_instr[i]);
    it.src1 = expect_src(wr_src1_type[i], wr_instr[i]);
    it.dest = expect_dest(wr_dest_type[i], wr_instr[i]);
    it.imm  = expect_imm(wr_imm_type[i], wr_instr[i], wr_pc[i]);
    return it;
  endfunction

  function automatic exp_item_t lane_item(input int k);
    exp_item_t it;
    it.pc   = dec_pc[k];
    it.src0 = dec_src0[k];
    it.src1 = dec_src1[k];
    it.dest = dec_dest[k];
    it.imm  = dec_imm[k];
    return it;
  endfunction

  // ====================
  // checking helpers

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_lane(input int k, input exp_item_t exp);
    check_value($sformatf("dec_pc_o[%0d]", k), exp.pc, dec_pc[k]);
    check_value($sformatf("dec_src0_o[%0d]", k), 32'(exp.src0), 32'(dec_src0[k]));
    check_value($sformatf("dec_src1_o[%0d]", k), 32'(exp.src1), 32'(dec_src1[k]));
    check_value($sformatf("dec_dest_o[%0d]", k), 32'(exp.dest), 32'(dec_dest[k]));
    check_value($sformatf("dec_imm_o[%0d]", k), exp.imm, dec_imm[k]);
  endtask

  task automatic finish_run();
    $display("checked %0d items over %0d flushes", items_checked, flush_count);
    $display("errors: value %0d, protocol %0d, timeout %0d",
             value_errors, protocol_errors, timeout_errors);
    if (value_errors + protocol_errors + timeout_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // ====================
  // stimulus

  // long stretches of low ready let the buffer fill up
  task automatic drive_random(input int cyc);
    int ready_pct;
    ready_pct = ((cyc % 500) < 100) ? 15 : 70;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      wr_valid[i]     <= ($urandom_range(99) < 60);
      wr_pc[i]        <= $urandom();
      wr_instr[i]     <= $urandom();
      wr_src0_type[i] <= src_type_e'($urandom_range(3));
      wr_src1_type[i] <= src_type_e'($urandom_range(3));
      wr_dest_type[i] <= dest_type_e'($urandom_range(3));
      wr_imm_type[i]  <= imm_type_e'($urandom_range(8));
    end
    dec_ready <= ($urandom_range(99) < ready_pct);
    flush     <= ($urandom_range(199) == 0);
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : main
    int drain_n;
    void'($urandom(SEED));
    rst_n        = 1'b0;
    flush        = 1'b0;
    wr_valid     = '0;
    wr_pc        = '0;
    wr_instr     = '0;
    wr_src0_type = {`FETCH_WIDTH{SRC_R0}};
    wr_src1_type = {`FETCH_WIDTH{SRC_R0}};
    wr_dest_type = {`FETCH_WIDTH{DEST_R0}};
    wr_imm_type  = {`FETCH_WIDTH{IMM_NONE}};
    dec_ready    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_value("dec_valid_o", 32'd0, 32'(dec_valid));
    check_value("wr_ready_o", 32'd1, 32'(wr_ready));

    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge clk);
      drive_random(cyc);
    end

    // drain what is left with the consumer always ready
    @(posedge clk);
    flush     <= 1'b0;
    wr_valid  <= '0;
    dec_ready <= 1'b1;
    drain_n = 0;
    while ((model_q.size() != 0 || dec_valid != '0) && drain_n < DRAIN_LIMIT) begin
      @(posedge clk);
      drain_n++;
    end
    assert (model_q.size() == 0 && dec_valid == '0) else begin
      protocol_errors++;
      $display("%0d accepted instructions never came out of the decode stage", model_q.size());
    end
    finish_run();
  end

  initial begin : watchdog
    #(PLANNED_CYCLES * CLK_PERIOD * 4);
    timeout_errors++;
    $display("timeout: the run did not finish within %0d cycles", PLANNED_CYCLES * 4);
    finish_run();
  end

  // ====================
  // monitor

  // sampled mid cycle where every signal is settled
  always @(negedge clk) begin : monitor
    int        n_out;
    int        buf_occ;
    logic      exp_ready;
    exp_item_t exp;
    if (rst_n) begin
      n_out = 0;
      assert (!(dec_valid[1] && !dec_valid[0])) else begin
        protocol_errors++;
        $display("%0t lane 1 holds a valid item while lane 0 is empty", $time);
      end
      for (int k = 0; k < `DECODE_WIDTH; k++) begin
        if (dec_valid[k]) n_out++;
      end

      // buffer occupancy is whatever is not sitting in the lanes
      buf_occ   = model_q.size() - n_out;
      exp_ready = (buf_occ <= `IBUF_DEPTH - `FETCH_WIDTH);
      check_value("wr_ready_o", 32'(exp_ready), 32'(wr_ready));

      if (flush_seen) begin
        check_value("dec_valid_o", 32'd0, 32'(dec_valid));
      end else if (hold_pending) begin
        check_value("dec_valid_o", 32'(held_valid), 32'(dec_valid));
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
          if (held_valid[k]) compare_lane(k, held_item[k]);
        end
      end

      // output handshake
      if (dec_ready) begin
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
          if (dec_valid[k]) begin
            assert (model_q.size() != 0) else begin
              protocol_errors++;
              $display("%0t lane %0d delivered an item that was never written", $time, k);
            end
            if (model_q.size() != 0) begin
              exp = model_q.pop_front();
              compare_lane(k, exp);
              items_checked++;
            end
          end
        end
      end

      hold_pending = dec_valid[0] && !dec_ready;
      held_valid   = dec_valid;
      for (int k = 0; k < `DECODE_WIDTH; k++) begin
        held_item[k] = lane_item(k);
      end

      // write acceptance with valid lanes packed in order
      if (!flush && wr_ready) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
          if (wr_valid[i]) model_q.push_back(model_item(i));
        end
      end

      flush_seen = flush;
      if (flush) begin
        model_q.delete();
        flush_count++;
      end
    end else begin
      flush_seen   = 1'b0;
      hold_pending = 1'b0;
    end
  end

endmodule

// ==== hdl/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// ====================
// front end widths

// instructions written by fetch per cycle
`define FETCH_WIDTH 2

// instructions read and decoded per cycle
`define DECODE_WIDTH 2

// instruction buffer entries, power of two
`define IBUF_DEPTH 8

// data and address width
`define XLEN 32

`endif

// ==== hdl/decode_lane.sv ====
`timescale 1ns/1ps

`include "decode_defines.svh"

module decode_lane (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  logic                  advance_i,
  input  logic                  slot_valid_i,
  input  ibuf_pkg::ibuf_entry_t slot_entry_i,
  output logic                  dec_valid_o,
  output instr_pkg::addr_t      dec_pc_o,
  output instr_pkg::arch_reg_t  dec_src0_o,
  output instr_pkg::arch_reg_t  dec_src1_o,
  output instr_pkg::arch_reg_t  dec_dest_o,
  output instr_pkg::word_t      dec_imm_o
);

  import instr_pkg::*;

  addr_t      slot_pc;
  instr_t     slot_instr;
  logic [1:0] src0_raw;
  logic [1:0] src1_raw;
  logic [1:0] dest_raw;
  logic [3:0] imm_raw;

  arch_reg_t src0_num;
  arch_reg_t src1_num;
  arch_reg_t dest_num;
  word_t     imm_val;

  // rd in 4:0, rj in 9:5, rk in 14:10
  function automatic arch_reg_t sel_src(input src_type_e t, input instr_t ins);
    arch_reg_t r;
    case (t)
      SRC_RD:  r = ins[4:0];
      SRC_RJ:  r = ins[9:5];
      SRC_RK:  r = ins[14:10];
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic word_t imm_ext(input imm_type_e t, input instr_t ins, input addr_t pc);
    word_t imm;
    case (t)
      IMM_UI5:  imm = word_t'(ins[14:10]);
      IMM_UI12: imm = word_t'(ins[21:10]);
      IMM_SI12: imm = word_t'($signed(ins[21:10]));
      IMM_SI14: imm = word_t'($signed(ins[23:10]));
      IMM_SI16: imm = word_t'($signed(ins[25:10]));
      IMM_SI20: imm = word_t'($signed(ins[24:5]));
      // offs[25:16] sits in the low bits of the word
      IMM_SI26: imm = word_t'($signed({ins[9:0], ins[25:10]}));
      IMM_PC:   imm = pc + word_t'($signed(ins[24:5]));
      default:  imm = '0;
    endcase
    return imm;
  endfunction

  // ====================
  // combinational decode

  assign {slot_pc, slot_instr, src0_raw, src1_raw, dest_raw, imm_raw} = slot_entry_i;

  assign src0_num = sel_src(src_type_e'(src0_raw), slot_instr);
  assign src1_num = sel_src(src_type_e'(src1_raw), slot_instr);

  always_comb begin
    case (dest_type_e'(dest_raw))
      DEST_RD: dest_num = slot_instr[4:0];
      DEST_JD: dest_num = slot_instr[9:5] | slot_instr[4:0];
      DEST_RA: dest_num = arch_reg_t'(1);
      default: dest_num = '0;
    endcase
  end

  assign imm_val = imm_ext(imm_type_e'(imm_raw), slot_instr, slot_pc);

  // ====================
  // output register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid_o <= 1'b0;
    end else if (flush_i) begin
      dec_valid_o <= 1'b0;
    end else if (advance_i) begin
      dec_valid_o <= slot_valid_i;
    end
  end

  // payload only moves with a valid slot
  always_ff @(posedge clk) begin
    if (advance_i && slot_valid_i) begin
      dec_pc_o   <= slot_pc;
      dec_src0_o <= src0_num;
      dec_src1_o <= src1_num;
      dec_dest_o <= dest_num;
      dec_imm_o  <= imm_val;
    end
  end

endmodule

// ==== hdl/decode_slice.sv ====
`timescale 1ns/1ps

`include "decode_defines.svh"

module decode_slice (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          flush_i,
  // fetch side
  input  logic [`FETCH_WIDTH-1:0]                       wr_valid_i,
  input  instr_pkg::addr_t [`FETCH_WIDTH-1:0]           wr_pc_i,
  input  instr_pkg::instr_t [`FETCH_WIDTH-1:0]          wr_instr_i,
  input  instr_pkg::src_type_e [`FETCH_WIDTH-1:0]       wr_src0_type_i,
  input  instr_pkg::src_type_e [`FETCH_WIDTH-1:0]       wr_src1_type_i,
  input  instr_pkg::dest_type_e [`FETCH_WIDTH-1:0]      wr_dest_type_i,
  input  instr_pkg::imm_type_e [`FETCH_WIDTH-1:0]       wr_imm_type_i,
  output logic                                          wr_ready_o,
  // decoded side
  input  logic                                          dec_ready_i,
  output logic [`DECODE_WIDTH-1:0]                      dec_valid_o,
  output instr_pkg::addr_t [`DECODE_WIDTH-1:0]          dec_pc_o,
  output instr_pkg::arch_reg_t [`DECODE_WIDTH-1:0]      dec_src0_o,
  output instr_pkg::arch_reg_t [`DECODE_WIDTH-1:0]      dec_src1_o,
  output instr_pkg::arch_reg_t [`DECODE_WIDTH-1:0]      dec_dest_o,
  output instr_pkg::word_t [`DECODE_WIDTH-1:0]          dec_imm_o
);

  import ibuf_pkg::*;

  ibuf_entry_t [`FETCH_WIDTH-1:0]  wr_entry;
  logic [`DECODE_WIDTH-1:0]        rd_valid;
  ibuf_entry_t [`DECODE_WIDTH-1:0] rd_entry;
  logic                            advance;

  // same field order the lanes unpack
  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      wr_entry[i] = {wr_pc_i[i], wr_instr_i[i], wr_src0_type_i[i], wr_src1_type_i[i],
                     wr_dest_type_i[i], wr_imm_type_i[i]};
    end
  end

  // lane 0 holds the oldest item, so it alone gates the stage
  assign advance = dec_ready_i | ~dec_valid_o[0];

  instr_buffer u_ibuf (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .advance_i  (advance),
    .wr_valid_i (wr_valid_i),
    .wr_entry_i (wr_entry),
    .wr_ready_o (wr_ready_o),
    .rd_valid_o (rd_valid),
    .rd_entry_o (rd_entry)
  );

  for (genvar i = 0; i < `DECODE_WIDTH; i++) begin : g_lane
    decode_lane u_lane (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush_i      (flush_i),
      .advance_i    (advance),
      .slot_valid_i (rd_valid[i]),
      .slot_entry_i (rd_entry[i]),
      .dec_valid_o  (dec_valid_o[i]),
      .dec_pc_o     (dec_pc_o[i]),
      .dec_src0_o   (dec_src0_o[i]),
      .dec_src1_o   (dec_src1_o[i]),
      .dec_dest_o   (dec_dest_o[i]),
      .dec_imm_o    (dec_imm_o[i])
    );
  end

endmodule

// ==== hdl/ibuf_pkg.sv ====
`include "decode_defines.svh"

package ibuf_pkg;

  // ====================
  // buffer bookkeeping

  typedef logic [$clog2(`IBUF_DEPTH)-1:0] ibuf_ptr_t;

  // one extra bit so a full buffer is representable
  typedef logic [$clog2(`IBUF_DEPTH):0] ibuf_cnt_t;

  // ====================
  // stored entry
  // layout msb to lsb is {pc, instr, src0, src1, dest, imm}
  // pc is XLEN, instr 32, three 2 bit codes and a 4 bit imm code
  typedef logic [`XLEN + 32 + 10 - 1:0] ibuf_entry_t;

endpackage

// ==== hdl/instr_buffer.sv ====
`timescale 1ns/1ps

`include "decode_defines.svh"

module instr_buffer (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush_i,
  input  logic                                      advance_i,
  input  logic [`FETCH_WIDTH-1:0]                   wr_valid_i,
  input  ibuf_pkg::ibuf_entry_t [`FETCH_WIDTH-1:0]  wr_entry_i,
  output logic                                      wr_ready_o,
  output logic [`DECODE_WIDTH-1:0]                  rd_valid_o,
  output ibuf_pkg::ibuf_entry_t [`DECODE_WIDTH-1:0] rd_entry_o
);

  import ibuf_pkg::*;

  ibuf_entry_t mem [`IBUF_DEPTH];

  ibuf_ptr_t rd_ptr;
  ibuf_ptr_t wr_ptr;
  ibuf_cnt_t count;
  ibuf_cnt_t free_cnt;

  logic                           wr_en;
  ibuf_cnt_t                      wr_num;
  ibuf_cnt_t                      wr_add;
  ibuf_ptr_t [`FETCH_WIDTH-1:0]   wr_idx;
  ibuf_cnt_t                      pop_num;

  // ====================
  // write side

  assign free_cnt   = ibuf_cnt_t'(`IBUF_DEPTH) - count;
  assign wr_ready_o = free_cnt >= ibuf_cnt_t'(`FETCH_WIDTH);

  // a flush in the same cycle drops the write
  assign wr_en = wr_ready_o & ~flush_i;

  // pack valid lanes onto consecutive slots
  always_comb begin
    wr_num = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      wr_idx[i] = wr_ptr + ibuf_ptr_t'(wr_num);
      wr_num    = wr_num + ibuf_cnt_t'(wr_valid_i[i]);
    end
  end

  assign wr_add = wr_en ? wr_num : '0;

  always_ff @(posedge clk) begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      if (wr_en && wr_valid_i[i]) begin
        mem[wr_idx[i]] <= wr_entry_i[i];
      end
    end
  end

  // ====================
  // read side

  // slot k valid once more than k entries are held
  always_comb begin
    for (int k = 0; k < `DECODE_WIDTH; k++) begin
      rd_valid_o[k] = count > ibuf_cnt_t'(k);
      rd_entry_o[k] = mem[rd_ptr + ibuf_ptr_t'(k)];
    end
  end

  // pop every presented slot on advance
  always_comb begin
    pop_num = '0;
    if (advance_i) begin
      for (int k = 0; k < `DECODE_WIDTH; k++) begin
        pop_num = pop_num + ibuf_cnt_t'(rd_valid_o[k]);
      end
    end
  end

  // ====================
  // pointers and occupancy

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + ibuf_ptr_t'(wr_add);
      rd_ptr <= rd_ptr + ibuf_ptr_t'(pop_num);
      count  <= count + wr_add - pop_num;
    end
  end

endmodule

// ==== hdl/instr_pkg.sv ====
`include "decode_defines.svh"

package instr_pkg;

  // ====================
  // instruction level vectors

  typedef logic [31:0] instr_t;
  typedef logic [`XLEN-1:0] addr_t;
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0] arch_reg_t;

  // ====================
  // pre-decode classes

  typedef enum logic [1:0] {
    SRC_R0 = 2'd0,
    SRC_RD = 2'd1,
    SRC_RJ = 2'd2,
    SRC_RK = 2'd3
  } src_type_e;

  // DEST_JD takes rj | rd, DEST_RA is the link register
  typedef enum logic [1:0] {
    DEST_R0 = 2'd0,
    DEST_RD = 2'd1,
    DEST_JD = 2'd2,
    DEST_RA = 2'd3
  } dest_type_e;

  typedef enum logic [3:0] {
    IMM_NONE = 4'd0,
    IMM_UI5  = 4'd1,
    IMM_UI12 = 4'd2,
    IMM_SI12 = 4'd3,
    IMM_SI14 = 4'd4,
    IMM_SI16 = 4'd5,
    IMM_SI20 = 4'd6,
    IMM_SI26 = 4'd7,
    IMM_PC   = 4'd8
  } imm_type_e;

endpackage

// ==== project.f ====
+incdir+hdl
hdl/instr_pkg.sv
hdl/ibuf_pkg.sv
hdl/instr_buffer.sv
hdl/decode_lane.sv
hdl/decode_slice.sv
dv/decode_slice_tb.sv
